/* bank_picker.sv */
// Round-robin picker over the bank queues
// Open-row tracking per bank
// ACTIVATE on a row miss, READ or WRITE with pop on a hit
`default_nettype none

module bank_picker
   import bs_pkg::*;
#(
   parameter int NUM_BANKS = 4
) (
   input  logic                 clk,
   input  logic                 rst_n,
   bank_queue_if.picker         q [NUM_BANKS],
   output logic                 cmd_valid,
   output bs_cmd_e              cmd_kind,
   output logic [BANK_BITS-1:0] cmd_bank,
   output logic [ROW_BITS-1:0]  cmd_row,
   output logic [COL_BITS-1:0]  cmd_col
);

   // Queue status collected into arrays
   logic [NUM_BANKS-1:0] empty_vec;
   bs_req_t              head_arr [NUM_BANKS];
   logic [NUM_BANKS-1:0] pop_vec;

   // Last granted bank
   logic [BANK_BITS-1:0] rr_ptr;

   // Open row per bank
   logic [ROW_BITS-1:0]  open_row [NUM_BANKS];
   logic [NUM_BANKS-1:0] open_vld;

   // Selection
   logic                 found;
   logic [BANK_BITS-1:0] sel;
   bs_req_t              sel_head;
   logic                 row_hit;

   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      assign empty_vec[i] = q[i].empty;
      assign head_arr[i]  = q[i].head;
      assign q[i].pop     = pop_vec[i];
      // Pop only the granted bank on a row hit
      assign pop_vec[i]   = found && row_hit && (sel == BANK_BITS'(i));
   end

   // First non-empty bank after the last grant, cyclic
   always_comb begin
      logic [BANK_BITS-1:0] idx;
      found = 1'b0;
      sel   = rr_ptr;
      for (int k = 1; k <= NUM_BANKS; k++) begin
         idx = BANK_BITS'((int'(rr_ptr) + k) % NUM_BANKS);
         if (!found && !empty_vec[idx]) begin
            found = 1'b1;
            sel   = idx;
         end
      end
   end

   assign sel_head = head_arr[sel];
   // Hit needs an open row equal to the head row
   assign row_hit  = open_vld[sel] && (open_row[sel] == sel_head.fields.row);

   // Grant state and open-row valid bits
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rr_ptr    <= BANK_BITS'(NUM_BANKS - 1);
         open_vld  <= '0;
         cmd_valid <= 1'b0;
      end else begin
         cmd_valid <= found;
         if (found) begin
            rr_ptr <= sel;
            if (!row_hit) begin
               open_vld[sel] <= 1'b1;
            end
         end
      end
   end

   // Open row and command payload
   always_ff @(posedge clk) begin
      if (found) begin
         cmd_bank <= sel;
         cmd_row  <= sel_head.fields.row;
         cmd_col  <= sel_head.fields.col;
         if (row_hit) begin
            cmd_kind <= sel_head.fields.is_write ? CMD_WR : CMD_RD;
         end else begin
            cmd_kind      <= CMD_ACT;
            open_row[sel] <= sel_head.fields.row;
         end
      end
   end

   // Issued command came from a queue that held an entry
   a_grant_nonempty: assert property (
      @(posedge clk) disable iff (!rst_n)
      cmd_valid |-> (($past(~empty_vec) & (NUM_BANKS'(1) << cmd_bank)) != '0)
   );

endmodule

`default_nettype wire

/* bank_queue.sv */
// Per-bank request FIFO
// Non-destructive head, element count, empty and full
// Protocol checks on push and pop
`default_nettype none

module bank_queue
   import bs_pkg::*;
#(
   parameter int DEPTH = 4
) (
   input  logic         clk,
   input  logic         rst_n,
   bank_queue_if.queue  q
);

   localparam int PTR_BITS = $clog2(DEPTH);

   // Entry storage and pointers
   logic [REQ_BITS-1:0] mem [DEPTH];
   logic [PTR_BITS-1:0] wr_ptr;
   logic [PTR_BITS-1:0] rd_ptr;
   // One bit wider so full and empty differ
   logic [PTR_BITS:0]   count;
   logic [REQ_BITS-1:0] head_raw;

   // Wrap at DEPTH, also for non power of two depths
   function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] p);
      return (p == PTR_BITS'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   // Status from the count
   assign q.empty = (count == '0);
   assign q.full  = (count == (PTR_BITS + 1)'(DEPTH));

   // Head shown in place, zero while empty
   assign head_raw = q.empty ? '0 : mem[rd_ptr];
   assign q.head   = bs_req_t'(head_raw);

   // Storage write, raw view of the entry
   always_ff @(posedge clk) begin
      if (q.push) begin
         mem[wr_ptr] <= q.entry.raw;
      end
   end

   // Pointers and count
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (q.push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (q.pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         // Push with pop keeps the count
         case ({q.push, q.pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Router must respect full
   a_no_push_full: assert property (
      @(posedge clk) disable iff (!rst_n)
      q.push |-> !q.full
   );

   // Picker must respect empty
   a_no_pop_empty: assert property (
      @(posedge clk) disable iff (!rst_n)
      q.pop |-> !q.empty
   );

   // Occupancy bound
   a_count_bound: assert property (
      @(posedge clk) disable iff (!rst_n)
      count <= (PTR_BITS + 1)'(DEPTH)
   );

endmodule

`default_nettype wire

/* bank_queue_if.sv */
// Per-bank queue bundle between router, queue and picker
// Push side, pop side and queue status
`default_nettype none

interface bank_queue_if
   import bs_pkg::*;
#(
   parameter int DEPTH = 4
);

   // Push side, from the router
   logic    push;
   bs_req_t entry;

   // Pop side, from the picker
   logic    pop;

   // Queue state, non-destructive head
   bs_req_t head;
   logic    empty;
   logic    full;

   // Pointer logic needs at least two entries
   if (DEPTH < 2) begin : g_depth_chk
      $error("bank_queue_if: DEPTH must be at least 2");
   end

   modport router (output push, output entry, input full);
   modport queue  (input push, input entry, input pop, output head, output empty, output full);
   modport picker (output pop, input head, input empty);

endinterface

`default_nettype wire

/* bank_scheduler_tb.sv */
// Bank scheduler testbench
// Directed fills, same-row bursts, random traffic
// Reference model of queues and open rows, output assertions, watchdog
`default_nettype none

module bank_scheduler_tb
   import bs_pkg::*;
;

   localparam int NUM_BANKS    = 4;
   localparam int DEPTH        = 4;
   localparam int PERIOD       = 20;
   localparam int RESET_CYCLES = 10;
   localparam int RAND_CYCLES  = 400;
   // Reset, settle, fill, bursts, random traffic, drain
   localparam int TEST_CYCLES  = RESET_CYCLES + 5 + 30 + 32 + RAND_CYCLES + 40;
   localparam int TIMEOUT      = (TEST_CYCLES + 200) * PERIOD;

   logic                 clk;
   logic                 rst_n;
   logic                 req_valid;
   logic [REQ_BITS-1:0]  req_word;
   logic                 req_drop;
   logic                 cmd_valid;
   bs_cmd_e              cmd_kind;
   logic [BANK_BITS-1:0] cmd_bank;
   logic [ROW_BITS-1:0]  cmd_row;
   logic [COL_BITS-1:0]  cmd_col;

   // Model state
   bs_req_t              mq [NUM_BANKS][$];
   logic [ROW_BITS-1:0]  m_row [NUM_BANKS];
   logic [NUM_BANKS-1:0] m_open;
   int                   m_rr;

   // Expected outputs after the current edge
   logic                 exp_valid;
   logic                 exp_drop;
   bs_cmd_e              exp_kind;
   logic [BANK_BITS-1:0] exp_bank;
   logic [ROW_BITS-1:0]  exp_row;
   logic [COL_BITS-1:0]  exp_col;

   integer seed;

   tb_clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(RESET_CYCLES)) i_clk (
      .clk   (clk),
      .rst_n (rst_n)
   );

   bank_scheduler_top #(.NUM_BANKS(NUM_BANKS), .DEPTH(DEPTH)) i_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (req_valid),
      .req_word  (req_word),
      .req_drop  (req_drop),
      .cmd_valid (cmd_valid),
      .cmd_kind  (cmd_kind),
      .cmd_bank  (cmd_bank),
      .cmd_row   (cmd_row),
      .cmd_col   (cmd_col)
   );

   task automatic stop_with_failure();
      $display("Errors found");
      $fatal(1, "Simulation stopped at the first failure");
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
      stop_with_failure();
   endtask

   // One request strobe, driven on the falling edge
   task automatic send_req(input logic wr, input logic [ROW_BITS-1:0] row,
                           input logic [BANK_BITS-1:0] bank,
                           input logic [COL_BITS-1:0] col);
      bs_req_t w;
      w.fields.is_write = wr;
      w.fields.row      = row;
      w.fields.bank     = bank;
      w.fields.col      = col;
      @(negedge clk);
      req_valid = 1'b1;
      req_word  = w.raw;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(negedge clk);
         req_valid = 1'b0;
      end
   endtask

   // Model steps once per edge, same view of the past as the DUT
   always @(posedge clk) begin
      bs_req_t req;
      bs_req_t hd;
      int      b;
      int      sel;
      int      cand;
      logic    drop;
      if (!rst_n) begin
         for (int i = 0; i < NUM_BANKS; i++) begin
            mq[i].delete();
         end
         m_open    = '0;
         m_rr      = NUM_BANKS - 1;
         exp_valid = 1'b0;
         exp_drop  = 1'b0;
      end else begin
         req.raw = req_word;
         b       = int'(req.fields.bank);
         // Occupancy before this edge decides a drop
         drop    = req_valid && (mq[b].size() == DEPTH);
         // Walk forward from the bank after the last grant
         sel = -1;
         for (int step = 1; step <= NUM_BANKS; step++) begin
            cand = (m_rr + step) % NUM_BANKS;
            if (sel < 0 && mq[cand].size() > 0) begin
               sel = cand;
            end
         end
         exp_valid = (sel >= 0);
         exp_drop  = drop;
         if (sel >= 0) begin
            hd       = mq[sel][0];
            exp_bank = BANK_BITS'(sel);
            exp_row  = hd.fields.row;
            exp_col  = hd.fields.col;
            m_rr     = sel;
            if (m_open[sel] && (m_row[sel] == hd.fields.row)) begin
               // Row hit, column command and pop
               exp_kind = hd.fields.is_write ? CMD_WR : CMD_RD;
               void'(mq[sel].pop_front());
            end else begin
               exp_kind    = CMD_ACT;
               m_open[sel] = 1'b1;
               m_row[sel]  = hd.fields.row;
            end
         end
         if (req_valid && !drop) begin
            mq[b].push_back(req);
         end
      end
   end

   // Output checks against the model
   a_valid: assert property (@(posedge clk) disable iff (!rst_n) cmd_valid == exp_valid)
      else report_mismatch("cmd_valid", $sampled(cmd_valid), $sampled(exp_valid));
   a_drop: assert property (@(posedge clk) disable iff (!rst_n) req_drop == exp_drop)
      else report_mismatch("req_drop", $sampled(req_drop), $sampled(exp_drop));
   a_bank: assert property (@(posedge clk) disable iff (!rst_n)
      exp_valid |-> cmd_bank == exp_bank)
      else report_mismatch("cmd_bank", $sampled(cmd_bank), $sampled(exp_bank));
   a_kind: assert property (@(posedge clk) disable iff (!rst_n)
      exp_valid |-> cmd_kind == exp_kind)
      else report_mismatch("cmd_kind", $sampled(cmd_kind), $sampled(exp_kind));
   a_row: assert property (@(posedge clk) disable iff (!rst_n)
      exp_valid |-> cmd_row == exp_row)
      else report_mismatch("cmd_row", $sampled(cmd_row), $sampled(exp_row));
   // Column only defined for READ and WRITE
   a_col: assert property (@(posedge clk) disable iff (!rst_n)
      (exp_valid && exp_kind != CMD_ACT) |-> cmd_col == exp_col)
      else report_mismatch("cmd_col", $sampled(cmd_col), $sampled(exp_col));

   // Watchdog
   initial begin
      #(TIMEOUT);
      $display("Timeout: the test sequence did not complete in time");
      stop_with_failure();
   end

   initial begin
      logic [31:0] r;
      seed      = 60727;
      req_valid = 1'b0;
      req_word  = '0;
      @(posedge rst_n);
      idle_cycles(5);

      // Fill bank 2 past DEPTH, a new row each time forces ACTs
      for (int i = 0; i < 10; i++) begin
         send_req(i[0], ROW_BITS'(i + 16), 2'd2, COL_BITS'(i));
      end
      idle_cycles(20);

      // Same-row bursts, one per bank
      for (int b = 0; b < NUM_BANKS; b++) begin
         for (int i = 0; i < 3; i++) begin
            send_req(i[0], ROW_BITS'(b + 5), BANK_BITS'(b), COL_BITS'(8 * b + i));
         end
      end
      idle_cycles(20);

      // Random traffic over rows 0 to 2
      repeat (RAND_CYCLES) begin
         r = $random(seed);
         if (r[1:0] != 2'b00) begin
            send_req(r[2], ROW_BITS'(r[4:3] % 3), r[6:5], r[14:7]);
         end else begin
            idle_cycles(1);
         end
      end
      idle_cycles(40);

      $display("No errors");
      $finish;
   end

endmodule

`default_nettype wire

/* bank_scheduler_top.sv */
// DRAM bank scheduler top level
// Router, one queue per bank, round-robin picker
`default_nettype none

module bank_scheduler_top
   import bs_pkg::*;
#(
   parameter int NUM_BANKS = 4,
   parameter int DEPTH     = 4
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 req_valid,
   input  logic [REQ_BITS-1:0]  req_word,
   output logic                 req_drop,
   output logic                 cmd_valid,
   output bs_cmd_e              cmd_kind,
   output logic [BANK_BITS-1:0] cmd_bank,
   output logic [ROW_BITS-1:0]  cmd_row,
   output logic [COL_BITS-1:0]  cmd_col
);

   // One bundle per bank
   bank_queue_if #(.DEPTH(DEPTH)) q_if [NUM_BANKS] ();

   request_router #(
      .NUM_BANKS (NUM_BANKS)
   ) i_router (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (req_valid),
      .req_word  (req_word),
      .req_drop  (req_drop),
      .q         (q_if)
   );

   // Identical queues
   for (genvar b = 0; b < NUM_BANKS; b++) begin : g_queue
      bank_queue #(
         .DEPTH (DEPTH)
      ) i_queue (
         .clk   (clk),
         .rst_n (rst_n),
         .q     (q_if[b])
      );
   end

   bank_picker #(
      .NUM_BANKS (NUM_BANKS)
   ) i_picker (
      .clk       (clk),
      .rst_n     (rst_n),
      .q         (q_if),
      .cmd_valid (cmd_valid),
      .cmd_kind  (cmd_kind),
      .cmd_bank  (cmd_bank),
      .cmd_row   (cmd_row),
      .cmd_col   (cmd_col)
   );

endmodule

`default_nettype wire

/* bs_pkg.sv */
// Shared widths for the bank scheduler
// Request word union with raw and field views
// Command kind encoding
`default_nettype none

package bs_pkg;

   // Address field widths
   localparam int ROW_BITS  = 12;
   localparam int COL_BITS  = 8;
   localparam int BANK_BITS = 2;

   // Write flag plus the three address fields
   localparam int REQ_BITS = 1 + ROW_BITS + BANK_BITS + COL_BITS;

   // Field view, MSB first
   typedef struct packed {
      logic                 is_write;
      logic [ROW_BITS-1:0]  row;
      logic [BANK_BITS-1:0] bank;
      logic [COL_BITS-1:0]  col;
   } bs_fields_t;

   // Raw bits for storage, fields for routing and issue
   typedef union packed {
      logic [REQ_BITS-1:0] raw;
      bs_fields_t          fields;
   } bs_req_t;

   // Command kinds on the DRAM side
   typedef enum logic [1:0] {
      CMD_ACT = 2'd0,
      CMD_RD  = 2'd1,
      CMD_WR  = 2'd2
   } bs_cmd_e;

endpackage

`default_nettype wire

/* list.f */
bs_pkg.sv
bank_queue_if.sv
request_router.sv
bank_queue.sv
bank_picker.sv
bank_scheduler_top.sv
tb_clock_gen.sv
bank_scheduler_tb.sv

/* request_router.sv */
// Request router
// Bank decode, push into the addressed queue, drop flag
`default_nettype none

module request_router
   import bs_pkg::*;
#(
   parameter int NUM_BANKS = 4
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            req_valid,
   input  bs_req_t         req_word,
   output logic            req_drop,
   bank_queue_if.router    q [NUM_BANKS]
);

   logic [BANK_BITS-1:0] bank;
   logic [NUM_BANKS-1:0] full_vec;
   logic                 hit_full;

   // Bank count is fixed by the bank field width
   if (NUM_BANKS != (1 << BANK_BITS)) begin : g_banks_chk
      $error("request_router: NUM_BANKS must equal 2**BANK_BITS");
   end

   // Field view of the incoming word
   assign bank = req_word.fields.bank;

   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      // Status gathered for indexing by bank
      assign full_vec[i] = q[i].full;

      // Push only the addressed queue, never into a full one
      assign q[i].push  = req_valid && (bank == BANK_BITS'(i)) && !q[i].full;
      assign q[i].entry = req_word;
   end

   assign hit_full = req_valid && full_vec[bank];

   // One-cycle drop flag, one edge after the request
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         req_drop <= 1'b0;
      end else begin
         req_drop <= hit_full;
      end
   end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
// Testbench clock and reset source
// Synchronous active-low reset held for a fixed number of cycles
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD       = 20,
   parameter int RESET_CYCLES = 10
) (
   output logic clk,
   output logic rst_n
);

   // Free-running clock
   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // Release on a falling edge, away from the sampling edge
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire
